// ==== bus_cfg_pkg.sv ====
`default_nettype none

package bus_cfg_pkg;

    // system sizes
    localparam int NUM_CACHES = 4;
    localparam int CACHE_ID_W = $clog2(NUM_CACHES);

    // one bus beat carries a whole block
    localparam int BEAT_WORDS = 4;
    localparam int BEAT_W     = BEAT_WORDS * 32;

    localparam int ADDR_W = 32;

    typedef logic [CACHE_ID_W-1:0] cache_id_t;
    typedef logic [BEAT_W-1:0]     beat_t;

endpackage

`default_nettype wire

// ==== bus_pkt_pkg.sv ====
`default_nettype none

package bus_pkt_pkg;

    import bus_cfg_pkg::*;

    // request kinds a cache can post to the bus
    typedef enum logic [1:0] {
        req_ld_shared,
        req_ld_exclusive,
        req_up_exclusive,
        req_write_back
    } bus_req_t;

    // wdata is only meaningful for write-backs
    typedef struct packed {
        bus_req_t            req_type;
        logic [ADDR_W-1:0]   addr;
        beat_t               wdata;
    } bus_pkt_t;

endpackage

`default_nettype wire

// ==== arb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface arb_if
    import bus_cfg_pkg::*;
();

    logic      grant_valid;
    cache_id_t grant_id;
    logic      grant_take;
    logic      release_valid;
    cache_id_t release_id;

    modport arb (
        output grant_valid, grant_id,
        input  grant_take, release_valid, release_id
    );

    modport ctrl (
        input  grant_valid, grant_id,
        output grant_take, release_valid, release_id
    );

endinterface

`default_nettype wire

// ==== fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_if
    import bus_cfg_pkg::*;
();

    logic      wr;
    cache_id_t wdata;
    logic      rd;
    cache_id_t rdata;
    logic      full;
    logic      empty;

    modport queue (
        input  wr, wdata, rd,
        output rdata, full, empty
    );

    modport user (
        output wr, wdata, rd,
        input  rdata, full, empty
    );

endinterface

`default_nettype wire

// ==== id_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_fifo
    import bus_cfg_pkg::*;
(
    input  logic  clk_i,
    input  logic  nreset_i,
    fifo_if.queue q
);

    cache_id_t           mem_r [NUM_CACHES];
    cache_id_t           wr_ptr_r;
    cache_id_t           rd_ptr_r;
    logic [CACHE_ID_W:0] count_r;
    logic                do_wr;
    logic                do_rd;

    assign q.full  = count_r == (CACHE_ID_W + 1)'(NUM_CACHES);
    assign q.empty = count_r == '0;
    assign q.rdata = mem_r[rd_ptr_r];

    // a read frees a slot for a write in the same cycle
    assign do_rd = q.rd & ~q.empty;
    assign do_wr = q.wr & (~q.full | do_rd);

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_r[wr_ptr_r] <= q.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_r <= wr_ptr_r + cache_id_t'(1);
            end
            if (do_rd) begin
                rd_ptr_r <= rd_ptr_r + cache_id_t'(1);
            end
            if (do_wr && !do_rd) begin
                count_r <= count_r + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lru_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_arbiter
    import bus_cfg_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  nreset_i,
    input  logic [NUM_CACHES-1:0] cb_valid_i,
    arb_if.arb                    a
);

    // rank 0 is the highest priority
    cache_id_t [NUM_CACHES-1:0] rank_r;
    logic [NUM_CACHES-1:0]      pend_r;
    logic [NUM_CACHES-1:0]      req;
    logic [NUM_CACHES-1:0]      take_mask;
    logic [NUM_CACHES-1:0]      rel_mask;
    cache_id_t                  best_rank;
    cache_id_t                  best_id;
    logic                       found;
    logic                       take;

    // caches with an entry already queued are not eligible
    assign req = cb_valid_i & ~pend_r;

    always_comb begin
        found     = 1'b0;
        best_rank = '1;
        best_id   = '0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (req[c] && (!found || rank_r[c] < best_rank)) begin
                found     = 1'b1;
                best_rank = rank_r[c];
                best_id   = cache_id_t'(c);
            end
        end
    end

    assign a.grant_valid = found;
    assign a.grant_id    = best_id;
    assign take          = a.grant_valid & a.grant_take;

    always_comb begin
        for (int c = 0; c < NUM_CACHES; c++) begin
            take_mask[c] = take & (best_id == cache_id_t'(c));
            rel_mask[c]  = a.release_valid & (a.release_id == cache_id_t'(c));
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int c = 0; c < NUM_CACHES; c++) begin
                rank_r[c] <= cache_id_t'(c);
            end
            pend_r <= '0;
        end else begin
            if (take) begin
                // winner drops to the back, the ones behind it move up
                for (int c = 0; c < NUM_CACHES; c++) begin
                    if (take_mask[c]) begin
                        rank_r[c] <= cache_id_t'(NUM_CACHES - 1);
                    end else if (rank_r[c] > best_rank) begin
                        rank_r[c] <= rank_r[c] - cache_id_t'(1);
                    end
                end
            end
            pend_r <= (pend_r & ~rel_mask) | take_mask;
        end
    end

endmodule

`default_nettype wire

// ==== snoop_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_merge
    import bus_cfg_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     nreset_i,
    input  logic                     tx_begin_i,
    input  logic                     tx_end_i,
    input  logic [NUM_CACHES-1:0]    sb_wait_i,
    input  logic [NUM_CACHES-1:0]    sb_hit_i,
    input  logic [NUM_CACHES-1:0]    sb_valid_i,
    input  beat_t [NUM_CACHES-1:0]   sb_data_i,
    output logic                     wait_any_o,
    output logic                     fwd_any_o,
    output beat_t                    fwd_data_o,
    output logic                     shared_o
);

    logic active_r;
    logic shared_r;

    // a snooper that already drives data is no longer waiting
    assign wait_any_o = |(sb_wait_i & ~sb_valid_i);
    assign fwd_any_o  = |sb_valid_i;
    assign shared_o   = shared_r;

    // at most one snooper forwards, so the last match is the only one
    always_comb begin
        fwd_data_o = '0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (sb_valid_i[c]) begin
                fwd_data_o = sb_data_i[c];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            active_r <= 1'b0;
            shared_r <= 1'b0;
        end else begin
            if (tx_end_i) begin
                active_r <= 1'b0;
            end else if (tx_begin_i) begin
                active_r <= 1'b1;
            end
            if (tx_begin_i) begin
                shared_r <= |sb_hit_i;
            end else if (active_r && |sb_hit_i) begin
                shared_r <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl
    import bus_cfg_pkg::*;
    import bus_pkt_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     nreset_i,
    input  logic [NUM_CACHES-1:0]    cb_valid_i,
    input  bus_pkt_t [NUM_CACHES-1:0] cb_pkt_i,
    output logic [NUM_CACHES-1:0]    cb_yumi_o,
    output logic [NUM_CACHES-1:0]    cb_valid_o,
    output logic                     cb_ld_ex_o,
    output beat_t                    cb_data_o,
    output logic [NUM_CACHES-1:0]    sb_valid_o,
    output logic                     sb_tx_begin_o,
    output bus_pkt_t                 sb_pkt_o,
    input  logic                     wait_any_i,
    input  logic                     fwd_any_i,
    input  beat_t                    fwd_data_i,
    input  logic                     shared_i,
    output logic                     tx_begin_o,
    output logic                     tx_end_o,
    input  logic                     mem_ready_i,
    output logic                     mem_valid_o,
    output logic                     mem_we_o,
    output logic [ADDR_W-1:0]        mem_addr_o,
    output beat_t                    mem_wdata_o,
    input  logic                     mem_valid_i,
    input  beat_t                    mem_data_i,
    arb_if.ctrl                      a,
    fifo_if.user                     oq,
    fifo_if.user                     iq
);

    typedef enum logic [1:0] {s_ready, s_wait, s_fwd, s_mem} state_t;

    state_t                state_r;
    state_t                state_n;
    cache_id_t             tx_id;
    bus_pkt_t              cur_pkt;
    bus_req_t              grant_req;
    logic [NUM_CACHES-1:0] tx_sel;
    logic                  is_up;
    logic                  is_wb;
    logic                  tx_begin;
    logic                  tx_active;
    logic                  settled;
    logic                  up_done;
    logic                  wb_done;
    logic                  fwd_done;
    logic                  rd_go;
    logic                  resp_done;
    logic                  tx_done;
    logic                  grant_is_load;

    // the transaction in progress is always the head of the out-queue
    assign tx_id     = oq.rdata;
    assign cur_pkt   = cb_pkt_i[tx_id];
    assign is_up     = cur_pkt.req_type == req_up_exclusive;
    assign is_wb     = cur_pkt.req_type == req_write_back;
    assign tx_begin  = (state_r == s_ready) & ~oq.empty;
    assign tx_active = (state_r != s_ready) | tx_begin;
    assign settled   = (state_r == s_wait) & ~wait_any_i;

    // a memory reply owns the response bus and the release port that cycle
    assign up_done   = settled & is_up & ~mem_valid_i;
    assign wb_done   = settled & is_wb & mem_ready_i & ~mem_valid_i;
    assign fwd_done  = (state_r == s_fwd) & mem_ready_i & ~mem_valid_i;
    assign rd_go     = (state_r == s_mem) & mem_ready_i & (~iq.full | iq.rd);
    assign resp_done = up_done | fwd_done;
    assign tx_done   = resp_done | wb_done | rd_go;

    always_comb begin
        state_n = state_r;
        case (state_r)
            s_ready: if (tx_begin) state_n = s_wait;
            s_wait: begin
                if (tx_done) begin
                    state_n = s_ready;
                end else if (settled && !is_up && !is_wb) begin
                    state_n = fwd_any_i ? s_fwd : s_mem;
                end
            end
            s_fwd:   if (fwd_done) state_n = s_ready;
            s_mem:   if (rd_go) state_n = s_ready;
            default: state_n = s_ready;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r <= s_ready;
        end else begin
            state_r <= state_n;
        end
    end

    // memory side, forwarded data goes to memory as well
    assign mem_valid_o = wb_done | fwd_done | rd_go;
    assign mem_we_o    = (state_r == s_fwd) | ((state_r == s_wait) & is_wb);
    assign mem_addr_o  = cur_pkt.addr;
    assign mem_wdata_o = (state_r == s_fwd) ? fwd_data_i : cur_pkt.wdata;

    // queues
    assign grant_req     = cb_pkt_i[a.grant_id].req_type;
    assign grant_is_load = (grant_req == req_ld_shared) | (grant_req == req_ld_exclusive);
    assign a.grant_take  = a.grant_valid & (~oq.full | oq.rd)
                         & (~grant_is_load | ~iq.full | iq.rd);
    assign oq.wr         = a.grant_take;
    assign oq.wdata      = a.grant_id;
    assign oq.rd         = tx_done;
    assign iq.wr         = rd_go;
    assign iq.wdata      = tx_id;
    assign iq.rd         = mem_valid_i;

    assign a.release_valid = mem_valid_i | resp_done | wb_done;
    assign a.release_id    = mem_valid_i ? iq.rdata : tx_id;

    always_comb begin
        for (int c = 0; c < NUM_CACHES; c++) begin
            tx_sel[c]     = tx_id == cache_id_t'(c);
            sb_valid_o[c] = tx_active & ~tx_sel[c];
            cb_yumi_o[c]  = tx_done & tx_sel[c] & cb_valid_i[c];
            cb_valid_o[c] = (mem_valid_i & (iq.rdata == cache_id_t'(c)))
                          | (resp_done & tx_sel[c]);
        end
    end

    assign cb_data_o     = mem_valid_i ? mem_data_i : fwd_data_i;
    assign cb_ld_ex_o    = ~shared_i;
    assign sb_pkt_o      = tx_active ? cur_pkt : '0;
    assign sb_tx_begin_o = tx_begin;
    assign tx_begin_o    = tx_begin;
    assign tx_end_o      = tx_done;

endmodule

`default_nettype wire

// ==== coherent_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module coherent_bus
    import bus_cfg_pkg::*;
    import bus_pkt_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      nreset_i,
    input  logic [NUM_CACHES-1:0]     cb_valid_i,
    input  bus_pkt_t [NUM_CACHES-1:0] cb_pkt_i,
    output logic [NUM_CACHES-1:0]     cb_yumi_o,
    input  logic [NUM_CACHES-1:0]     sb_wait_i,
    input  logic [NUM_CACHES-1:0]     sb_hit_i,
    input  logic [NUM_CACHES-1:0]     sb_valid_i,
    input  beat_t [NUM_CACHES-1:0]    sb_data_i,
    output logic [NUM_CACHES-1:0]     sb_valid_o,
    output logic                      sb_tx_begin_o,
    output bus_pkt_t                  sb_pkt_o,
    input  logic                      mem_ready_i,
    output logic                      mem_valid_o,
    output logic                      mem_we_o,
    output logic [ADDR_W-1:0]         mem_addr_o,
    output beat_t                     mem_wdata_o,
    input  logic                      mem_valid_i,
    input  beat_t                     mem_data_i,
    output logic [NUM_CACHES-1:0]     cb_valid_o,
    output logic                      cb_ld_ex_o,
    output beat_t                     cb_data_o
);

    logic  wait_any;
    logic  fwd_any;
    beat_t fwd_data;
    logic  shared;
    logic  tx_begin;
    logic  tx_end;

    arb_if  arb_bus ();
    fifo_if out_q ();
    fifo_if in_q ();

    lru_arbiter u_arbiter (
        .clk_i, .nreset_i, .cb_valid_i, .a(arb_bus.arb)
    );

    // ids waiting for their bus transaction
    id_fifo u_out_fifo (.clk_i, .nreset_i, .q(out_q.queue));

    // ids waiting for their memory reply
    id_fifo u_in_fifo (.clk_i, .nreset_i, .q(in_q.queue));

    snoop_merge u_snoop (
        .clk_i, .nreset_i,
        .tx_begin_i(tx_begin), .tx_end_i(tx_end),
        .sb_wait_i, .sb_hit_i, .sb_valid_i, .sb_data_i,
        .wait_any_o(wait_any), .fwd_any_o(fwd_any),
        .fwd_data_o(fwd_data), .shared_o(shared)
    );

    bus_ctrl u_ctrl (
        .clk_i, .nreset_i, .cb_valid_i, .cb_pkt_i, .cb_yumi_o,
        .cb_valid_o, .cb_ld_ex_o, .cb_data_o,
        .sb_valid_o, .sb_tx_begin_o, .sb_pkt_o,
        .wait_any_i(wait_any), .fwd_any_i(fwd_any),
        .fwd_data_i(fwd_data), .shared_i(shared),
        .tx_begin_o(tx_begin), .tx_end_o(tx_end),
        .mem_ready_i, .mem_valid_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
        .mem_valid_i, .mem_data_i,
        .a(arb_bus.ctrl), .oq(out_q.user), .iq(in_q.user)
    );

endmodule

`default_nettype wire

// ==== bus_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_properties
    import bus_cfg_pkg::*;
(
    input logic                  clk_i,
    input logic                  nreset_i,
    input logic [NUM_CACHES-1:0] sb_valid_i,
    input logic                  mem_valid_i,
    input logic                  iq_empty_i,
    input logic                  iq_rd_i,
    input logic                  oq_empty_i,
    input logic                  oq_rd_i
);

    // only one peer may own the block dirty
    one_forwarder: assert property (@(posedge clk_i) disable iff (nreset_i)
        $onehot0(sb_valid_i))
        else $error("more than one snooper drives forwarded data");

    reply_has_owner: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_i |-> !iq_empty_i)
        else $error("memory reply with no id in the in-queue");

    in_queue_read: assert property (@(posedge clk_i) disable iff (nreset_i)
        iq_rd_i |-> !iq_empty_i)
        else $error("in-queue read while empty");

    out_queue_read: assert property (@(posedge clk_i) disable iff (nreset_i)
        oq_rd_i |-> !oq_empty_i)
        else $error("out-queue read while empty");

endmodule

// snoop inputs are only visible at the top level
bind coherent_bus bus_properties u_props (
    .clk_i,
    .nreset_i,
    .sb_valid_i,
    .mem_valid_i,
    .iq_empty_i(in_q.empty),
    .iq_rd_i(in_q.rd),
    .oq_empty_i(out_q.empty),
    .oq_rd_i(out_q.rd)
);

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic nreset_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // reset seen high on the first three rising edges
    initial begin
        nreset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        nreset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_coherent_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_coherent_bus
    import bus_cfg_pkg::*;
    import bus_pkt_pkg::*;
();

    logic                      clk;
    logic                      nreset;
    logic [NUM_CACHES-1:0]     cb_valid;
    bus_pkt_t [NUM_CACHES-1:0] cb_pkt;
    logic [NUM_CACHES-1:0]     cb_yumi;
    logic [NUM_CACHES-1:0]     sb_wait;
    logic [NUM_CACHES-1:0]     sb_hit;
    logic [NUM_CACHES-1:0]     sb_valid;
    beat_t [NUM_CACHES-1:0]    sb_data;
    logic [NUM_CACHES-1:0]     sb_valid_out;
    logic                      sb_tx_begin;
    bus_pkt_t                  sb_pkt;
    logic                      mem_ready;
    logic                      mem_valid_out;
    logic                      mem_we;
    logic [ADDR_W-1:0]         mem_addr;
    beat_t                     mem_wdata;
    logic                      mem_valid_in;
    beat_t                     mem_data;
    logic [NUM_CACHES-1:0]     cb_valid_out;
    logic                      cb_ld_ex;
    beat_t                     cb_data;

    // memory model and monitor state
    beat_t                 mem_lines [16];
    logic [ADDR_W-1:0]     rd_addr_q [$];
    int                    rd_due_q [$];
    int                    cycle;
    int                    rd_count;
    int                    wr_count;
    logic [ADDR_W-1:0]     last_rd_addr;
    logic [ADDR_W-1:0]     last_wr_addr;
    beat_t                 last_wr_data;
    int                    tx_count;
    logic [NUM_CACHES-1:0] tx_sb_valid;
    bus_pkt_t              tx_pkt;
    int                    yumi_count [NUM_CACHES];
    int                    dropped [NUM_CACHES];
    int                    resp_id_q [$];
    beat_t                 resp_data_q [$];
    logic                  resp_ldex_q [$];
    int                    resp_idx;
    integer                seed;

    tb_clkgen u_clkgen (.clk_o(clk), .nreset_o(nreset));

    coherent_bus uut (
        .clk_i(clk), .nreset_i(nreset),
        .cb_valid_i(cb_valid), .cb_pkt_i(cb_pkt), .cb_yumi_o(cb_yumi),
        .sb_wait_i(sb_wait), .sb_hit_i(sb_hit), .sb_valid_i(sb_valid),
        .sb_data_i(sb_data), .sb_valid_o(sb_valid_out),
        .sb_tx_begin_o(sb_tx_begin), .sb_pkt_o(sb_pkt),
        .mem_ready_i(mem_ready), .mem_valid_o(mem_valid_out), .mem_we_o(mem_we),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .mem_valid_i(mem_valid_in), .mem_data_i(mem_data),
        .cb_valid_o(cb_valid_out), .cb_ld_ex_o(cb_ld_ex), .cb_data_o(cb_data)
    );

    // initial memory contents, every word depends on the line address
    function automatic beat_t fill_beat(input logic [ADDR_W-1:0] addr);
        return {~addr, addr + 32'h0101_0101, addr ^ 32'h5a5a_5a5a, addr};
    endfunction

    // memory takes requests on the rising edge and answers two cycles later
    initial begin
        mem_ready = 1'b1;
        mem_valid_in = 1'b0;
        mem_data = '0;
        for (int i = 0; i < 16; i++) begin
            mem_lines[i] = fill_beat(32'(i) << 4);
        end
        forever begin
            @(posedge clk);
            cycle++;
            if (!nreset && mem_valid_out) begin
                if (mem_we) begin
                    wr_count++;
                    last_wr_addr = mem_addr;
                    last_wr_data = mem_wdata;
                    mem_lines[mem_addr[7:4]] = mem_wdata;
                end else begin
                    rd_count++;
                    last_rd_addr = mem_addr;
                    rd_addr_q.push_back(mem_addr);
                    rd_due_q.push_back(cycle + 1);
                end
            end
            @(negedge clk);
            mem_valid_in = 1'b0;
            mem_data = '0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                mem_valid_in = 1'b1;
                mem_data = mem_lines[rd_addr_q[0][7:4]];
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
        end
    end

    // cache side monitor
    initial begin
        forever begin
            @(posedge clk);
            if (!nreset) begin
                for (int c = 0; c < NUM_CACHES; c++) begin
                    if (cb_yumi[c]) begin
                        yumi_count[c]++;
                    end
                    if (cb_valid_out[c]) begin
                        resp_id_q.push_back(c);
                        resp_data_q.push_back(cb_data);
                        resp_ldex_q.push_back(cb_ld_ex);
                    end
                end
                if (sb_tx_begin) begin
                    tx_count++;
                    tx_sb_valid = sb_valid_out;
                    tx_pkt = sb_pkt;
                end
            end
        end
    end

    task automatic fail_now();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input logic [BEAT_W-1:0] act, input logic [BEAT_W-1:0] exp,
                         input string what);
        if (act !== exp) begin
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, act, exp);
            fail_now();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        fail_now();
    endtask

    // one cycle, caches drop their request after yumi
    task automatic step();
        @(negedge clk);
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (dropped[c] != yumi_count[c]) begin
                cb_valid[c] = 1'b0;
                dropped[c] = yumi_count[c];
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic set_req(input int c, input bus_req_t kind, input logic [ADDR_W-1:0] addr,
                           input beat_t wdata);
        cb_pkt[c].req_type = kind;
        cb_pkt[c].addr = addr;
        cb_pkt[c].wdata = wdata;
        cb_valid[c] = 1'b1;
    endtask

    task automatic post(input int c, input bus_req_t kind, input logic [ADDR_W-1:0] addr,
                        input beat_t wdata);
        step();
        set_req(c, kind, addr, wdata);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (nreset) begin
            if (n == 20) begin
                timed_out("reset to be released");
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic wait_tx(input int start);
        int n;
        n = 0;
        while (tx_count == start) begin
            if (n == 100) begin
                timed_out("a bus transaction to begin");
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic wait_yumi(input int c, input int start);
        int n;
        n = 0;
        while (yumi_count[c] == start) begin
            if (n == 100) begin
                timed_out("yumi to the requesting cache");
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic wait_resp(output int id, output beat_t data, output logic ldex);
        int n;
        n = 0;
        while (resp_id_q.size() <= resp_idx) begin
            if (n == 100) begin
                timed_out("a response to a cache");
            end else begin
                step();
                n++;
            end
        end
        id = resp_id_q[resp_idx];
        data = resp_data_q[resp_idx];
        ldex = resp_ldex_q[resp_idx];
        resp_idx++;
    endtask

    // all four caches at once, a second load from cache 0, then 3 and 0 together
    task automatic test_order();
        int    order [7];
        int    addrs [7];
        int    r0;
        int    id;
        beat_t data;
        logic  ldex;
        order = '{0, 1, 2, 3, 0, 3, 0};
        addrs = '{32'h00, 32'h10, 32'h20, 32'h30, 32'h50, 32'h60, 32'h70};
        r0 = rd_count;
        step();
        for (int c = 0; c < NUM_CACHES; c++) begin
            set_req(c, req_ld_shared, addrs[c], '0);
        end
        for (int k = 0; k < 7; k++) begin
            wait_resp(id, data, ldex);
            check(id, order[k], "service order");
            check(data, fill_beat(addrs[k]), "load data");
            if (k == 0) begin
                post(0, req_ld_shared, addrs[4], '0);
            end else if (k == 4) begin
                // cache 0 was granted last, so cache 3 now ranks above it
                post(3, req_ld_shared, addrs[5], '0);
                set_req(0, req_ld_shared, addrs[6], '0);
            end
        end
        idle(8);
        check(resp_id_q.size(), resp_idx, "extra responses");
        check(yumi_count[0], 3, "yumi count of cache 0");
        check(yumi_count[1], 1, "yumi count of cache 1");
        check(yumi_count[2], 1, "yumi count of cache 2");
        check(yumi_count[3], 2, "yumi count of cache 3");
        check(rd_count - r0, 7, "memory reads");
    endtask

    task automatic test_load_plain();
        int    r0;
        int    w0;
        int    id;
        beat_t data;
        logic  ldex;
        r0 = rd_count;
        w0 = wr_count;
        post(1, req_ld_shared, 32'h40, '0);
        wait_resp(id, data, ldex);
        check(id, 1, "responder");
        check(data, fill_beat(32'h40), "load data");
        check(ldex, 1'b1, "exclusive flag");
        check(rd_count - r0, 1, "memory reads");
        check(last_rd_addr, 32'h40, "memory read address");
        check(wr_count - w0, 0, "memory writes");
    endtask

    task automatic test_load_shared();
        int    r0;
        int    t0;
        int    id;
        beat_t data;
        logic  ldex;
        r0 = rd_count;
        t0 = tx_count;
        post(1, req_ld_shared, 32'h40, '0);
        sb_wait[2] = 1'b1;
        wait_tx(t0);
        check(tx_sb_valid, 4'b1101, "snoop broadcast mask");
        check(tx_pkt.addr, 32'h40, "snoop address");
        // cache 2 finishes its tag lookup and holds the block clean
        step();
        sb_wait[2] = 1'b0;
        sb_hit[2] = 1'b1;
        wait_resp(id, data, ldex);
        sb_hit[2] = 1'b0;
        check(id, 1, "responder");
        check(data, fill_beat(32'h40), "load data");
        check(ldex, 1'b0, "exclusive flag");
        check(rd_count - r0, 1, "memory reads");
    endtask

    task automatic test_forward();
        int    r0;
        int    w0;
        int    t0;
        int    id;
        beat_t fwd;
        beat_t data;
        logic  ldex;
        fwd = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r0 = rd_count;
        w0 = wr_count;
        t0 = tx_count;
        post(0, req_ld_exclusive, 32'h80, '0);
        sb_wait[3] = 1'b1;
        wait_tx(t0);
        // dirty copy in cache 3
        sb_hit[3] = 1'b1;
        sb_valid[3] = 1'b1;
        sb_data[3] = fwd;
        wait_resp(id, data, ldex);
        sb_wait[3] = 1'b0;
        sb_hit[3] = 1'b0;
        sb_valid[3] = 1'b0;
        sb_data[3] = '0;
        check(id, 0, "responder");
        check(data, fwd, "forwarded data");
        check(wr_count - w0, 1, "memory writes");
        check(last_wr_addr, 32'h80, "memory write address");
        check(last_wr_data, fwd, "memory write data");
        check(rd_count - r0, 0, "memory reads");
    endtask

    task automatic test_write_back();
        int    w0;
        int    y0;
        beat_t wb;
        wb = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
        w0 = wr_count;
        y0 = yumi_count[0];
        post(0, req_write_back, 32'hc0, wb);
        wait_yumi(0, y0);
        check(wr_count - w0, 1, "memory writes");
        check(last_wr_addr, 32'hc0, "memory write address");
        check(last_wr_data, wb, "memory write data");
        idle(6);
        check(resp_id_q.size(), resp_idx, "response after write-back");
    endtask

    task automatic test_upgrade();
        int    r0;
        int    w0;
        int    y0;
        int    id;
        beat_t data;
        logic  ldex;
        r0 = rd_count;
        w0 = wr_count;
        y0 = yumi_count[2];
        post(2, req_up_exclusive, 32'h40, '0);
        wait_resp(id, data, ldex);
        check(id, 2, "responder");
        check(yumi_count[2] - y0, 1, "yumi count of cache 2");
        check(rd_count - r0, 0, "memory reads");
        check(wr_count - w0, 0, "memory writes");
    endtask

    initial begin
        seed = 32'hc5c2e49b;
        cb_valid = '0;
        cb_pkt = '0;
        sb_wait = '0;
        sb_hit = '0;
        sb_valid = '0;
        sb_data = '0;
        wait_reset();
        test_order();
        test_load_plain();
        test_load_shared();
        test_forward();
        test_write_back();
        test_upgrade();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
bus_cfg_pkg.sv
bus_pkt_pkg.sv
arb_if.sv
fifo_if.sv
id_fifo.sv
lru_arbiter.sv
snoop_merge.sv
bus_ctrl.sv
coherent_bus.sv
bus_properties.sv
tb_clkgen.sv
tb_coherent_bus.sv
